// ==== source/cpuTypesPkg.sv ====
package cpuTypesPkg;

    localparam int dataWidth = 32;
    localparam int addrWidth = 32;
    localparam int opWidth   = 4;

    typedef logic [dataWidth-1:0] dataT;
    typedef logic [addrWidth-1:0] addrT;

    // control-transfer operations seen by the branch path
    typedef enum logic [opWidth-1:0] {
        opNop  = 4'd0,
        opBeq  = 4'd1,
        opBne  = 4'd2,
        opBlt  = 4'd3,
        opBge  = 4'd4,
        opBltu = 4'd5,
        opBgeu = 4'd6,
        opJal  = 4'd7,
        opJalr = 4'd8
    } branchOpT;

    localparam dataT dataFree = '0;
    localparam addrT addrFree = '0;

    // distance from a branch to the instruction after it
    localparam addrT instBytes = 32'd4;

endpackage

// ==== source/stationPkg.sv ====
package stationPkg;

    localparam int tagWidth = 4;

    // tag zero marks an operand whose value is already held
    typedef logic [tagWidth-1:0] tagT;
    localparam tagT tagFree = '0;

    localparam int rsSize = 4;

    typedef logic [$clog2(rsSize)-1:0] rsIndexT;
    typedef logic [rsSize-1:0] rsMaskT;

endpackage

// ==== source/operandSnoop.sv ====
module operandSnoop (
    input  logic               aluWrtEn,
    input  logic               lsWrtEn,
    input  stationPkg::tagT    aluTag,
    input  stationPkg::tagT    lsTag,
    input  stationPkg::tagT    tagNow,
    input  cpuTypesPkg::dataT  aluData,
    input  cpuTypesPkg::dataT  lsData,
    input  cpuTypesPkg::dataT  dataNow,
    output stationPkg::tagT    tagNext,
    output cpuTypesPkg::dataT  dataNext
);
    import stationPkg::*;

    logic waiting;

    assign waiting = (tagNow != tagFree);

    // a tag is only ever broadcast once, so the bus order only matters on paper
    always_comb begin
        if (waiting && aluWrtEn && (aluTag == tagNow)) begin
            tagNext  = tagFree;
            dataNext = aluData;
        end else if (waiting && lsWrtEn && (lsTag == tagNow)) begin
            tagNext  = tagFree;
            dataNext = lsData;
        end else begin
            tagNext  = tagNow;
            dataNext = dataNow;
        end
    end

endmodule

// ==== source/stationLine.sv ====
module stationLine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  occupied,
    input  logic                  allocEn,
    input  logic                  aluWrtEn,
    input  stationPkg::tagT       aluTag,
    input  cpuTypesPkg::dataT     aluData,
    input  logic                  lsWrtEn,
    input  stationPkg::tagT       lsTag,
    input  cpuTypesPkg::dataT     lsData,
    input  cpuTypesPkg::dataT     allocOperandO,
    input  cpuTypesPkg::dataT     allocOperandT,
    input  stationPkg::tagT       allocTagO,
    input  stationPkg::tagT       allocTagT,
    input  cpuTypesPkg::branchOpT allocOp,
    input  cpuTypesPkg::dataT     allocImm,
    input  cpuTypesPkg::addrT     allocPc,
    output logic                  ready,
    output cpuTypesPkg::dataT     issueOperandO,
    output cpuTypesPkg::dataT     issueOperandT,
    output cpuTypesPkg::dataT     issueImm,
    output cpuTypesPkg::branchOpT issueOp,
    output cpuTypesPkg::addrT     issuePc
);
    import cpuTypesPkg::*;
    import stationPkg::*;

    tagT      storedTagO;
    tagT      storedTagT;
    dataT     storedDataO;
    dataT     storedDataT;
    branchOpT storedOp;
    dataT     storedImm;
    addrT     storedPc;
    tagT      tagCurO;
    tagT      tagCurT;
    dataT     dataCurO;
    dataT     dataCurT;
    tagT      tagNextO;
    tagT      tagNextT;
    dataT     dataNextO;
    dataT     dataNextT;

    // an incoming instruction is snooped as well, so a wakeup in its own cycle is kept
    assign tagCurO  = allocEn ? allocTagO : storedTagO;
    assign tagCurT  = allocEn ? allocTagT : storedTagT;
    assign dataCurO = allocEn ? allocOperandO : storedDataO;
    assign dataCurT = allocEn ? allocOperandT : storedDataT;

    operandSnoop uSnoopO (
        .aluWrtEn (aluWrtEn),
        .lsWrtEn  (lsWrtEn),
        .aluTag   (aluTag),
        .lsTag    (lsTag),
        .tagNow   (tagCurO),
        .aluData  (aluData),
        .lsData   (lsData),
        .dataNow  (dataCurO),
        .tagNext  (tagNextO),
        .dataNext (dataNextO)
    );

    operandSnoop uSnoopT (
        .aluWrtEn (aluWrtEn),
        .lsWrtEn  (lsWrtEn),
        .aluTag   (aluTag),
        .lsTag    (lsTag),
        .tagNow   (tagCurT),
        .aluData  (aluData),
        .lsData   (lsData),
        .dataNow  (dataCurT),
        .tagNext  (tagNextT),
        .dataNext (dataNextT)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            storedTagO <= tagFree;
            storedTagT <= tagFree;
            storedOp   <= opNop;
        end else begin
            storedTagO <= tagNextO;
            storedTagT <= tagNextT;
            if (allocEn) begin
                storedOp <= allocOp;
            end
        end
    end

    always_ff @(posedge clk) begin
        storedDataO <= dataNextO;
        storedDataT <= dataNextT;
        if (allocEn) begin
            storedImm <= allocImm;
            storedPc  <= allocPc;
        end
    end

    // ready looks at next-cycle tags so bus data can go straight to issue
    assign ready         = occupied && (tagNextO == tagFree) && (tagNextT == tagFree);
    assign issueOperandO = dataNextO;
    assign issueOperandT = dataNextT;
    assign issueImm      = storedImm;
    assign issueOp       = storedOp;
    assign issuePc       = storedPc;

endmodule

// ==== source/branchStation.sv ====
module branchStation (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  allocEn,
    input  cpuTypesPkg::dataT     allocOperandO,
    input  cpuTypesPkg::dataT     allocOperandT,
    input  stationPkg::tagT       allocTagO,
    input  stationPkg::tagT       allocTagT,
    input  cpuTypesPkg::branchOpT allocOp,
    input  cpuTypesPkg::dataT     allocImm,
    input  cpuTypesPkg::addrT     allocPc,
    input  logic                  aluWrtEn,
    input  stationPkg::tagT       aluTag,
    input  cpuTypesPkg::dataT     aluData,
    input  logic                  lsWrtEn,
    input  stationPkg::tagT       lsTag,
    input  cpuTypesPkg::dataT     lsData,
    output stationPkg::rsMaskT    freeStatus,
    output logic                  issueEn,
    output cpuTypesPkg::dataT     issueOperandO,
    output cpuTypesPkg::dataT     issueOperandT,
    output cpuTypesPkg::dataT     issueImm,
    output cpuTypesPkg::branchOpT issueOp,
    output cpuTypesPkg::addrT     issuePc
);
    import cpuTypesPkg::*;
    import stationPkg::*;

    rsIndexT  head;
    rsIndexT  tail;
    rsMaskT   occupied;
    rsMaskT   lineAlloc;
    rsMaskT   lineReady;
    logic     allocHit;
    logic     canIssue;
    dataT     lineOperandO [rsSize];
    dataT     lineOperandT [rsSize];
    dataT     lineImm [rsSize];
    branchOpT lineOp [rsSize];
    addrT     linePc [rsSize];

    // a request is dropped when the tail entry is still taken
    assign allocHit = allocEn && !occupied[tail];
    assign canIssue = lineReady[head];

    always_comb begin
        lineAlloc       = '0;
        lineAlloc[tail] = allocHit;
    end

    for (genvar i = 0; i < rsSize; i++) begin : gLine
        stationLine uLine (
            .clk           (clk),
            .rst           (rst),
            .occupied      (occupied[i]),
            .allocEn       (lineAlloc[i]),
            .aluWrtEn      (aluWrtEn),
            .aluTag        (aluTag),
            .aluData       (aluData),
            .lsWrtEn       (lsWrtEn),
            .lsTag         (lsTag),
            .lsData        (lsData),
            .allocOperandO (allocOperandO),
            .allocOperandT (allocOperandT),
            .allocTagO     (allocTagO),
            .allocTagT     (allocTagT),
            .allocOp       (allocOp),
            .allocImm      (allocImm),
            .allocPc       (allocPc),
            .ready         (lineReady[i]),
            .issueOperandO (lineOperandO[i]),
            .issueOperandT (lineOperandT[i]),
            .issueImm      (lineImm[i]),
            .issueOp       (lineOp[i]),
            .issuePc       (linePc[i])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head          <= '0;
            tail          <= '0;
            occupied      <= '0;
            issueEn       <= 1'b0;
            issueOperandO <= dataFree;
            issueOperandT <= dataFree;
            issueImm      <= dataFree;
            issueOp       <= opNop;
            issuePc       <= addrFree;
        end else begin
            if (allocHit) begin
                occupied[tail] <= 1'b1;
                tail           <= tail + rsIndexT'(1);
            end
            if (canIssue) begin
                occupied[head] <= 1'b0;
                head           <= head + rsIndexT'(1);
                issueEn        <= 1'b1;
                issueOperandO  <= lineOperandO[head];
                issueOperandT  <= lineOperandT[head];
                issueImm       <= lineImm[head];
                issueOp        <= lineOp[head];
                issuePc        <= linePc[head];
            end else begin
                issueEn       <= 1'b0;
                issueOperandO <= dataFree;
                issueOperandT <= dataFree;
                issueImm      <= dataFree;
                issueOp       <= opNop;
                issuePc       <= addrFree;
            end
        end
    end

    assign freeStatus = ~occupied;

endmodule

// ==== source/branchCompare.sv ====
module branchCompare (
    input  cpuTypesPkg::branchOpT op,
    input  cpuTypesPkg::dataT     operandO,
    input  cpuTypesPkg::dataT     operandT,
    output logic                  taken
);
    import cpuTypesPkg::*;

    logic isEqual;
    logic lessSigned;
    logic lessUnsigned;

    assign isEqual      = (operandO == operandT);
    assign lessSigned   = ($signed(operandO) < $signed(operandT));
    assign lessUnsigned = (operandO < operandT);

    always_comb begin
        case (op)
            opBeq: begin
                taken = isEqual;
            end
            opBne: begin
                taken = !isEqual;
            end
            opBlt: begin
                taken = lessSigned;
            end
            opBge: begin
                taken = !lessSigned;
            end
            opBltu: begin
                taken = lessUnsigned;
            end
            opBgeu: begin
                taken = !lessUnsigned;
            end
            // jumps always leave the sequential path
            opJal, opJalr: begin
                taken = 1'b1;
            end
            default: begin
                taken = 1'b0;
            end
        endcase
    end

endmodule

// ==== source/branchTarget.sv ====
module branchTarget (
    input  cpuTypesPkg::branchOpT op,
    input  cpuTypesPkg::dataT     operandO,
    input  cpuTypesPkg::dataT     imm,
    input  cpuTypesPkg::addrT     pc,
    output cpuTypesPkg::addrT     target,
    output cpuTypesPkg::addrT     fallThrough,
    output cpuTypesPkg::dataT     link
);
    import cpuTypesPkg::*;

    logic isJump;
    addrT pcRelative;
    addrT regRelative;

    assign isJump = (op == opJal) || (op == opJalr);

    assign pcRelative  = pc + addrT'(imm);
    assign regRelative = addrT'(operandO + imm);

    // JALR drops bit 0 of the sum as RV32 requires
    assign target = (op == opJalr) ? {regRelative[addrWidth-1:1], 1'b0} : pcRelative;

    assign fallThrough = pc + instBytes;
    assign link        = isJump ? dataT'(fallThrough) : dataFree;

endmodule

// ==== source/branchResolve.sv ====
module branchResolve (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issueEn,
    input  logic                  taken,
    input  cpuTypesPkg::branchOpT op,
    input  cpuTypesPkg::addrT     target,
    input  cpuTypesPkg::addrT     fallThrough,
    input  cpuTypesPkg::dataT     link,
    output logic                  branchDone,
    output logic                  branchTaken,
    output cpuTypesPkg::addrT     branchTarget,
    output cpuTypesPkg::dataT     linkData
);
    import cpuTypesPkg::*;

    logic isJump;

    assign isJump = (op == opJal) || (op == opJalr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            branchDone   <= 1'b0;
            branchTaken  <= 1'b0;
            branchTarget <= addrFree;
            linkData     <= dataFree;
        end else if (issueEn) begin
            branchDone  <= 1'b1;
            branchTaken <= taken;
            // a branch that is not taken continues at the next instruction
            branchTarget <= taken ? target : fallThrough;
            linkData     <= isJump ? link : dataFree;
        end else begin
            branchDone   <= 1'b0;
            branchTaken  <= 1'b0;
            branchTarget <= addrFree;
            linkData     <= dataFree;
        end
    end

endmodule

// ==== source/branchUnit.sv ====
module branchUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  aluWrtEn,
    input  stationPkg::tagT       aluTag,
    input  cpuTypesPkg::dataT     aluData,
    input  logic                  lsWrtEn,
    input  stationPkg::tagT       lsTag,
    input  cpuTypesPkg::dataT     lsData,
    input  logic                  allocEn,
    input  cpuTypesPkg::dataT     allocOperandO,
    input  cpuTypesPkg::dataT     allocOperandT,
    input  stationPkg::tagT       allocTagO,
    input  stationPkg::tagT       allocTagT,
    input  cpuTypesPkg::branchOpT allocOp,
    input  cpuTypesPkg::dataT     allocImm,
    input  cpuTypesPkg::addrT     allocPc,
    output stationPkg::rsMaskT    freeStatus,
    output logic                  branchDone,
    output logic                  branchTaken,
    output cpuTypesPkg::addrT     branchTarget,
    output cpuTypesPkg::dataT     linkData
);
    import cpuTypesPkg::*;

    logic     issueEn;
    dataT     issueOperandO;
    dataT     issueOperandT;
    dataT     issueImm;
    branchOpT issueOp;
    addrT     issuePc;
    logic     cmpTaken;
    addrT     targetAddr;
    addrT     fallThrough;
    dataT     linkValue;

    branchStation uStation (
        .clk           (clk),
        .rst           (rst),
        .allocEn       (allocEn),
        .allocOperandO (allocOperandO),
        .allocOperandT (allocOperandT),
        .allocTagO     (allocTagO),
        .allocTagT     (allocTagT),
        .allocOp       (allocOp),
        .allocImm      (allocImm),
        .allocPc       (allocPc),
        .aluWrtEn      (aluWrtEn),
        .aluTag        (aluTag),
        .aluData       (aluData),
        .lsWrtEn       (lsWrtEn),
        .lsTag         (lsTag),
        .lsData        (lsData),
        .freeStatus    (freeStatus),
        .issueEn       (issueEn),
        .issueOperandO (issueOperandO),
        .issueOperandT (issueOperandT),
        .issueImm      (issueImm),
        .issueOp       (issueOp),
        .issuePc       (issuePc)
    );

    // condition and address are worked out side by side on the issued branch
    branchCompare uCompare (
        .op       (issueOp),
        .operandO (issueOperandO),
        .operandT (issueOperandT),
        .taken    (cmpTaken)
    );

    branchTarget uTarget (
        .op          (issueOp),
        .operandO    (issueOperandO),
        .imm         (issueImm),
        .pc          (issuePc),
        .target      (targetAddr),
        .fallThrough (fallThrough),
        .link        (linkValue)
    );

    branchResolve uResolve (
        .clk          (clk),
        .rst          (rst),
        .issueEn      (issueEn),
        .taken        (cmpTaken),
        .op           (issueOp),
        .target       (targetAddr),
        .fallThrough  (fallThrough),
        .link         (linkValue),
        .branchDone   (branchDone),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .linkData     (linkData)
    );

endmodule

// ==== tb/clockGen.sv ====
module clockGen (
    output logic clk,
    output logic rst
);
    localparam int period      = 40;
    localparam int resetCycles = 2;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // reset drops on a falling edge, away from the active edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== tb/branchUnitTb.sv ====
module branchUnitTb;
    import cpuTypesPkg::*;
    import stationPkg::*;

    localparam int clkPeriod     = 40;
    localparam int testCount     = 6;
    localparam int cyclesPerTest = 400;
    localparam int marginCycles  = 200;
    localparam int stepLimit     = 100;

    logic     clk;
    logic     rst;
    logic     aluWrtEn;
    tagT      aluTag;
    dataT     aluData;
    logic     lsWrtEn;
    tagT      lsTag;
    dataT     lsData;
    logic     allocEn;
    dataT     allocOperandO;
    dataT     allocOperandT;
    tagT      allocTagO;
    tagT      allocTagT;
    branchOpT allocOp;
    dataT     allocImm;
    addrT     allocPc;
    rsMaskT   freeStatus;
    logic     branchDone;
    logic     branchTaken;
    addrT     branchTarget;
    dataT     linkData;

    integer seed;
    integer errors;
    integer checkCount;
    integer cycleCount;
    integer doneCount;
    integer doneCycle;
    integer allocCount;
    integer lastAllocEdge;

    // expected outcomes in allocation order
    dataT expTakenQ [$];
    addrT expTargetQ [$];
    dataT expLinkQ [$];

    clockGen uClock (
        .clk (clk),
        .rst (rst)
    );

    branchUnit u_dut (
        .clk           (clk),
        .rst           (rst),
        .aluWrtEn      (aluWrtEn),
        .aluTag        (aluTag),
        .aluData       (aluData),
        .lsWrtEn       (lsWrtEn),
        .lsTag         (lsTag),
        .lsData        (lsData),
        .allocEn       (allocEn),
        .allocOperandO (allocOperandO),
        .allocOperandT (allocOperandT),
        .allocTagO     (allocTagO),
        .allocTagT     (allocTagT),
        .allocOp       (allocOp),
        .allocImm      (allocImm),
        .allocPc       (allocPc),
        .freeStatus    (freeStatus),
        .branchDone    (branchDone),
        .branchTaken   (branchTaken),
        .branchTarget  (branchTarget),
        .linkData      (linkData)
    );

    task automatic checkValue(input string name, input dataT got, input dataT expected);
        checkCount = checkCount + 1;
        if (got !== expected) begin
            errors = errors + 1;
            $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    // reference model built from the RV32 control-transfer rules
    task automatic pushExpected(input branchOpT op, input dataT a, input dataT b,
                                input dataT imm, input addrT pc);
        logic taken;
        addrT target;
        dataT link;
        case (op)
            opBeq:         taken = (a == b);
            opBne:         taken = (a != b);
            opBlt:         taken = ($signed(a) < $signed(b));
            opBge:         taken = ($signed(a) >= $signed(b));
            opBltu:        taken = (a < b);
            opBgeu:        taken = (a >= b);
            opJal, opJalr: taken = 1'b1;
            default:       taken = 1'b0;
        endcase
        if (!taken) begin
            target = pc + 32'd4;
        end else if (op == opJalr) begin
            target = (a + imm) & ~32'd1;
        end else begin
            target = pc + imm;
        end
        link = ((op == opJal) || (op == opJalr)) ? pc + 32'd4 : 32'd0;
        expTakenQ.push_back({31'b0, taken});
        expTargetQ.push_back(target);
        expLinkQ.push_back(link);
        allocCount = allocCount + 1;
    endtask

    task automatic driveAlloc(input branchOpT op, input dataT a, input dataT b,
                              input tagT tagO, input tagT tagT2, input dataT imm,
                              input addrT pc);
        allocEn       = 1'b1;
        allocOp       = op;
        allocOperandO = a;
        allocOperandT = b;
        allocTagO     = tagO;
        allocTagT     = tagT2;
        allocImm      = imm;
        allocPc       = pc;
        lastAllocEdge = cycleCount + 1;
    endtask

    task automatic driveAlu(input tagT tag, input dataT data);
        aluWrtEn = 1'b1;
        aluTag   = tag;
        aluData  = data;
    endtask

    task automatic driveLs(input tagT tag, input dataT data);
        lsWrtEn = 1'b1;
        lsTag   = tag;
        lsData  = data;
    endtask

    task automatic nextCycle();
        @(negedge clk);
        allocEn  = 1'b0;
        aluWrtEn = 1'b0;
        lsWrtEn  = 1'b0;
    endtask

    task automatic waitOutcomes();
        integer n;
        n = 0;
        @(posedge clk);
        while ((doneCount < allocCount) && (n < stepLimit)) begin
            @(posedge clk);
            n = n + 1;
        end
        if (doneCount < allocCount) begin
            errors = errors + 1;
            $display("only %0d of %0d branch outcomes arrived within %0d cycles",
                     doneCount, allocCount, stepLimit);
        end
        @(negedge clk);
    endtask

    task automatic idleAndCheck(input integer cycles, input integer expected, input string name);
        repeat (cycles) @(posedge clk);
        checkValue(name, doneCount, expected);
        @(negedge clk);
    endtask

    task automatic testReset();
        checkValue("freeStatus after reset", dataT'(freeStatus), 32'hF);
        repeat (10) @(posedge clk);
        checkValue("outcomes while idle", doneCount, 32'd0);
        @(negedge clk);
    endtask

    task automatic testAllOps();
        branchOpT op;
        dataT     a;
        dataT     b;
        dataT     imm;
        addrT     pc;
        for (int i = 0; i < 8; i++) begin
            op = branchOpT'(i + 1);
            for (int k = 0; k < 4; k++) begin
                a   = $random(seed);
                b   = $random(seed);
                imm = $random(seed);
                imm = {{20{imm[11]}}, imm[11:1], 1'b0};
                pc  = $random(seed);
                pc  = pc & 32'hFFFF_FFFC;
                case (k)
                    0: b = a;
                    1: begin
                        a = a | 32'h8000_0000;
                        b = b & 32'h7FFF_FFFF;
                    end
                    2: begin
                        a = a & 32'h0000_FFFF;
                        b = b | 32'hF000_0000;
                    end
                    default: ;
                endcase
                driveAlloc(op, a, b, tagFree, tagFree, imm, pc);
                pushExpected(op, a, b, imm, pc);
                nextCycle();
                waitOutcomes();
                checkValue("latency with operands ready", doneCycle - lastAllocEdge, 32'd2);
            end
        end
    endtask

    task automatic testWakeup();
        dataT   d0;
        dataT   d1;
        integer base;
        base = allocCount;
        d0 = $random(seed);
        d0 = d0 | 32'h8000_0000;
        d1 = $random(seed);
        d1 = d1 & 32'h7FFF_FFFF;
        driveAlloc(opBlt, ~d0, ~d1, 4'd3, 4'd5, 32'h0000_0040, 32'h0000_1000);
        pushExpected(opBlt, d0, d1, 32'h0000_0040, 32'h0000_1000);
        nextCycle();
        idleAndCheck(3, base, "outcomes before first wakeup");
        driveAlu(4'd3, d0);
        nextCycle();
        idleAndCheck(3, base, "outcomes before second wakeup");
        driveLs(4'd5, d1);
        nextCycle();
        waitOutcomes();
    endtask

    task automatic testSameCycle();
        dataT d0;
        dataT d1;
        d0 = $random(seed);
        d1 = $random(seed);
        driveAlloc(opBgeu, ~d0, ~d1, 4'd7, 4'd8, 32'hFFFF_FFF0, 32'h0000_2000);
        driveAlu(4'd7, d0);
        driveLs(4'd8, d1);
        pushExpected(opBgeu, d0, d1, 32'hFFFF_FFF0, 32'h0000_2000);
        nextCycle();
        waitOutcomes();
        checkValue("latency with wakeup at allocation", doneCycle - lastAllocEdge, 32'd2);
        driveAlloc(opJalr, 32'd0, 32'd0, 4'd9, tagFree, 32'h0000_0007, 32'h0000_3000);
        driveLs(4'd9, d1);
        pushExpected(opJalr, d1, 32'd0, 32'h0000_0007, 32'h0000_3000);
        nextCycle();
        waitOutcomes();
    endtask

    task automatic testInOrder();
        dataT   d9;
        integer base;
        base = allocCount;
        d9 = $random(seed);
        driveAlloc(opBne, ~d9, d9, 4'd9, tagFree, 32'h0000_0100, 32'h0000_4000);
        pushExpected(opBne, d9, d9, 32'h0000_0100, 32'h0000_4000);
        nextCycle();
        driveAlloc(opJal, 32'd0, 32'd0, tagFree, tagFree, 32'h0000_0800, 32'h0000_4004);
        pushExpected(opJal, 32'd0, 32'd0, 32'h0000_0800, 32'h0000_4004);
        nextCycle();
        driveAlloc(opBeq, d9, d9, tagFree, tagFree, 32'hFFFF_FF00, 32'h0000_4008);
        pushExpected(opBeq, d9, d9, 32'hFFFF_FF00, 32'h0000_4008);
        nextCycle();
        driveAlloc(opBltu, 32'd1, 32'd2, tagFree, tagFree, 32'h0000_0020, 32'h0000_400C);
        pushExpected(opBltu, 32'd1, 32'd2, 32'h0000_0020, 32'h0000_400C);
        nextCycle();
        idleAndCheck(4, base, "outcomes while the head waits");
        driveLs(4'd9, d9);
        nextCycle();
        waitOutcomes();
    endtask

    task automatic testFull();
        dataT     d [4];
        branchOpT ops [4];
        integer   base;
        base   = allocCount;
        ops[0] = opBge;
        ops[1] = opBne;
        ops[2] = opJal;
        ops[3] = opBltu;
        for (int i = 0; i < 4; i++) begin
            d[i] = $random(seed);
            driveAlloc(ops[i], 32'h0000_5555, ~d[i], tagFree, tagT'(i + 1), 32'h0000_0010,
                       addrT'(32'h0000_5000 + 4 * i));
            pushExpected(ops[i], 32'h0000_5555, d[i], 32'h0000_0010,
                         addrT'(32'h0000_5000 + 4 * i));
            nextCycle();
        end
        checkValue("freeStatus when full", dataT'(freeStatus), 32'h0);
        // the station is full, so this request must be dropped
        driveAlloc(opJal, 32'd0, 32'd0, tagFree, tagFree, 32'h0000_0004, 32'h0000_6000);
        nextCycle();
        checkValue("freeStatus after dropped request", dataT'(freeStatus), 32'h0);
        idleAndCheck(2, base, "outcomes while full");
        for (int i = 0; i < 4; i++) begin
            if (i % 2 == 0) begin
                driveAlu(tagT'(i + 1), d[i]);
            end else begin
                driveLs(tagT'(i + 1), d[i]);
            end
            nextCycle();
        end
        waitOutcomes();
        idleAndCheck(5, allocCount, "outcomes after drain");
        checkValue("freeStatus after drain", dataT'(freeStatus), 32'hF);
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (branchDone) begin
            doneCount = doneCount + 1;
            doneCycle = cycleCount;
            if (expTargetQ.size() == 0) begin
                errors = errors + 1;
                $display("a branch outcome appeared at time %0t with no branch waiting", $time);
            end else begin
                checkValue("branchTaken", {31'b0, branchTaken}, expTakenQ.pop_front());
                checkValue("branchTarget", branchTarget, expTargetQ.pop_front());
                checkValue("linkData", linkData, expLinkQ.pop_front());
            end
        end
    end

    initial begin
        #((testCount * cyclesPerTest + marginCycles) * clkPeriod);
        $display("timeout: the tests did not finish within %0d cycles",
                 testCount * cyclesPerTest + marginCycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        seed          = 32'h83fc2868;
        errors        = 0;
        checkCount    = 0;
        cycleCount    = 0;
        doneCount     = 0;
        doneCycle     = 0;
        allocCount    = 0;
        lastAllocEdge = 0;
        aluWrtEn      = 1'b0;
        aluTag        = tagFree;
        aluData       = dataFree;
        lsWrtEn       = 1'b0;
        lsTag         = tagFree;
        lsData        = dataFree;
        allocEn       = 1'b0;
        allocOperandO = dataFree;
        allocOperandT = dataFree;
        allocTagO     = tagFree;
        allocTagT     = tagFree;
        allocOp       = opNop;
        allocImm      = dataFree;
        allocPc       = addrFree;
        @(negedge rst);
        testReset();
        testAllOps();
        testWakeup();
        testSameCycle();
        testInOrder();
        testFull();
        if (expTargetQ.size() != 0) begin
            errors = errors + 1;
            $display("%0d expected branch outcomes never arrived", expTargetQ.size());
        end
        $display("checks %0d, errors %0d", checkCount, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
source/cpuTypesPkg.sv
source/stationPkg.sv
source/operandSnoop.sv
source/stationLine.sv
source/branchStation.sv
source/branchCompare.sv
source/branchTarget.sv
source/branchResolve.sv
source/branchUnit.sv
tb/clockGen.sv
tb/branchUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= branchUnitTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
